//--- Bender.yml
package:
  name: pcie_f2c

sources:
  - hdl/pcie_pkg.sv
  - hdl/ring_ctrl_if.sv
  - hdl/pio_regs.sv
  - hdl/f2c_ring.sv
  - hdl/pcie_top.sv
  - target: simulation
    files:
      - verif/tb_pcie_top.sv

//--- hdl/f2c_ring.sv
`timescale 1ns/10ps

module f2c_ring #(
    parameter int  RB_DEPTH           = 256,
    parameter int  ALMOST_FULL_MARGIN = 16,
    localparam int RB_AWIDTH          = $clog2(RB_DEPTH)
) (
    input  logic                 pcie_clk,
    input  logic                 pcie_reset_n,
    input  logic                 wr_en,
    input  logic [RB_AWIDTH-1:0] wr_addr,
    input  pcie_pkg::flit_t      wr_data,
    input  logic                 update_valid,
    input  logic [RB_AWIDTH-1:0] update_size,
    output logic [RB_AWIDTH-1:0] wr_base_addr,
    output logic                 wr_base_addr_valid,
    output logic                 almost_full,
    input  logic                 desc_ready,
    output logic                 desc_valid,
    output pcie_pkg::wrdm_desc_t desc_data,
    input  logic                 buf_read,
    input  logic [RB_AWIDTH-1:0] buf_line,
    output pcie_pkg::flit_t      buf_readdata,
    output logic                 buf_readvalid,
    ring_ctrl_if.ring_side       ring
);

    localparam int PTR_WIDTH = pcie_pkg::RB_SIZE_WIDTH;

    // SETTLE covers the cycle the register file needs to present the next app
    typedef enum logic [1:0] {S_IDLE, S_DESC, S_DONE, S_SETTLE} state_e;

    state_e               state;
    pcie_pkg::flit_t      mem [RB_DEPTH];
    pcie_pkg::flit_t      rd_q;
    logic                 rd_v1;

    logic [RB_AWIDTH-1:0] wr_ptr;
    logic [RB_AWIDTH:0]   used;
    logic [RB_AWIDTH:0]   used_next;
    logic                 pend_valid;
    logic [RB_AWIDTH-1:0] pend_start;
    logic [RB_AWIDTH-1:0] pend_size;

    logic                 issue;
    logic                 xfer;
    logic [RB_AWIDTH-1:0] issue_start;
    logic [RB_AWIDTH-1:0] issue_size;
    logic [PTR_WIDTH-1:0] cur_tail;
    logic [RB_AWIDTH-1:0] cur_size;
    logic [PTR_WIDTH:0]   tail_sum;
    logic [7:0]           desc_cnt;

    // flit memory, datapath writes and two-cycle host reads
    always_ff @(posedge pcie_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_q         <= mem[buf_line];
        buf_readdata <= rd_q;
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            rd_v1         <= 1'b0;
            buf_readvalid <= 1'b0;
        end else begin
            rd_v1         <= buf_read;
            buf_readvalid <= rd_v1;
        end
    end

    assign xfer        = desc_valid && desc_ready;
    assign issue       = (state == S_IDLE) && ring.ring_enable && (pend_valid || update_valid);
    assign issue_start = pend_valid ? pend_start : wr_ptr;
    assign issue_size  = pend_valid ? pend_size : update_size;

    assign desc_valid    = state == S_DESC;
    assign ring.dma_done = state == S_DONE;
    assign wr_base_addr  = wr_ptr;

    // slots held by PDUs whose descriptor has not transferred
    always_comb begin
        used_next = used;
        if (update_valid) begin
            used_next = used_next + (RB_AWIDTH+1)'(update_size);
        end
        if (xfer) begin
            used_next = used_next - (RB_AWIDTH+1)'(cur_size);
        end
    end

    // next tail, wraps at the host ring size
    always_comb begin
        tail_sum = {1'b0, cur_tail} + (PTR_WIDTH+1)'(cur_size);
        if (tail_sum >= {1'b0, ring.rb_size}) begin
            ring.new_tail = PTR_WIDTH'(tail_sum - {1'b0, ring.rb_size});
        end else begin
            ring.new_tail = tail_sum[PTR_WIDTH-1:0];
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            state              <= S_IDLE;
            pend_valid         <= 1'b0;
            wr_ptr             <= '0;
            used               <= '0;
            almost_full        <= 1'b0;
            wr_base_addr_valid <= 1'b0;
            desc_cnt           <= '0;
        end else begin
            wr_base_addr_valid <= 1'b1;
            used               <= used_next;
            almost_full        <= (RB_DEPTH - int'(used_next)) < ALMOST_FULL_MARGIN;
            if (update_valid) begin
                wr_ptr <= wr_ptr + update_size;
            end
            // pending slot drains into the descriptor, refills from a new update
            if (issue && pend_valid) begin
                pend_valid <= update_valid;
            end else if (update_valid && !issue) begin
                pend_valid <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (issue) begin
                        state    <= S_DESC;
                        desc_cnt <= desc_cnt + 1'b1;
                    end
                end
                S_DESC: begin
                    if (desc_ready) begin
                        state <= S_DONE;
                    end
                end
                S_DONE:  state <= S_SETTLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (update_valid && !(issue && !pend_valid)) begin
            pend_start <= wr_ptr;
            pend_size  <= update_size;
        end
        if (issue) begin
            cur_tail            <= ring.tail;
            cur_size            <= issue_size;
            desc_data.dest_addr <= ring.kmem_addr + (64'(ring.tail) << 6);
            desc_data.src_addr  <= 64'(issue_start) << 6;
            desc_data.size_dw   <= 18'(issue_size) << 4;
            desc_data.desc_id   <= desc_cnt;
            desc_data.app_id    <= 4'(ring.app_id);
            desc_data.rsvd      <= '0;
        end
    end

    assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        desc_valid && !desc_ready |=> desc_valid && $stable(desc_data))
        else $error("descriptor changed while stalled");

    // only an idle, enabled engine frees the pending slot in the same cycle
    assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        update_valid && pend_valid |-> (state == S_IDLE) && ring.ring_enable)
        else $error("update dropped, descriptor and pending slot both busy");

    assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        update_valid |-> update_size != '0)
        else $error("update with zero size");

endmodule

//--- hdl/pcie_pkg.sv
package pcie_pkg;

    // PIO port 0 geometry, one line is one flit
    localparam int PCIE_ADDR_WIDTH = 16;
    localparam int FLIT_WIDTH      = 512;

    // lines below the buffer window hold the registers (bytes 0x0000-0x0fff)
    localparam int RB_BRAM_OFFSET  = 64;

    // dwords per application page, one 64-byte line per page
    localparam int REGS_PER_PAGE   = 4;

    localparam logic [PCIE_ADDR_WIDTH-1:0] CTRL_BYTE_ADDR = 16'h0800;

    // host ring index width, follows the rb_size field
    localparam int RB_SIZE_WIDTH   = 26;

    // dword offsets inside an application page
    typedef enum logic [1:0] {
        REG_TAIL      = 2'd0,
        REG_HEAD      = 2'd1,
        REG_KMEM_LOW  = 2'd2,
        REG_KMEM_HIGH = 2'd3
    } reg_off_e;

    typedef logic [FLIT_WIDTH-1:0] flit_t;

    // write-DMA descriptor, 174 bits
    typedef struct packed {
        logic [63:0] dest_addr;
        logic [63:0] src_addr;
        logic [17:0] size_dw;
        logic [7:0]  desc_id;
        logic [3:0]  app_id;
        logic [15:0] rsvd;
    } wrdm_desc_t;

    // control register, disable sits in bit 0
    typedef struct packed {
        logic [4:0]               total_apps;
        logic [RB_SIZE_WIDTH-1:0] rb_size;
        logic                     disable_bit;
    } ctrl_t;

endpackage

//--- hdl/pcie_top.sv
`timescale 1ns/10ps

module pcie_top #(
    parameter int  MAX_NB_APPS        = 4,
    parameter int  RB_DEPTH           = 256,
    parameter int  ALMOST_FULL_MARGIN = 16,
    localparam int RB_AWIDTH          = $clog2(RB_DEPTH)
) (
    input  logic                                    pcie_clk,
    input  logic                                    pcie_reset_n,
    input  logic [pcie_pkg::PCIE_ADDR_WIDTH-1:0]    pcie_address_0,
    input  logic                                    pcie_read_0,
    input  logic                                    pcie_write_0,
    input  pcie_pkg::flit_t                         pcie_writedata_0,
    input  logic [pcie_pkg::FLIT_WIDTH/8-1:0]       pcie_byteenable_0,
    output pcie_pkg::flit_t                         pcie_readdata_0,
    output logic                                    pcie_readdatavalid_0,
    input  logic                                    pcie_rb_wr_en,
    input  logic [RB_AWIDTH-1:0]                    pcie_rb_wr_addr,
    input  pcie_pkg::flit_t                         pcie_rb_wr_data,
    output logic [RB_AWIDTH-1:0]                    pcie_rb_wr_base_addr,
    output logic                                    pcie_rb_wr_base_addr_valid,
    output logic                                    pcie_rb_almost_full,
    input  logic                                    pcie_rb_update_valid,
    input  logic [RB_AWIDTH-1:0]                    pcie_rb_update_size,
    input  logic                                    pcie_wrdm_desc_ready,
    output logic                                    pcie_wrdm_desc_valid,
    output logic [$bits(pcie_pkg::wrdm_desc_t)-1:0] pcie_wrdm_desc_data,
    output logic                                    disable_pcie
);

    logic [pcie_pkg::PCIE_ADDR_WIDTH-7:0] pio_line;
    pcie_pkg::flit_t                      reg_readdata;
    logic                                 reg_readdatavalid;
    pcie_pkg::flit_t                      buf_readdata;
    logic                                 buf_readvalid;
    logic                                 buf_read;
    logic [RB_AWIDTH-1:0]                 buf_line;

    ring_ctrl_if #(.MAX_NB_APPS(MAX_NB_APPS)) ring ();

    // lines from RB_BRAM_OFFSET upward map onto the ring buffer
    assign pio_line = pcie_address_0[pcie_pkg::PCIE_ADDR_WIDTH-1:6];
    assign buf_read = pcie_read_0 && (pio_line >= pcie_pkg::RB_BRAM_OFFSET);
    assign buf_line = RB_AWIDTH'(pio_line - pcie_pkg::RB_BRAM_OFFSET);

    // both sources answer with the same latency, never together
    assign pcie_readdata_0      = reg_readdatavalid ? reg_readdata : buf_readdata;
    assign pcie_readdatavalid_0 = reg_readdatavalid || buf_readvalid;

    pio_regs #(.MAX_NB_APPS(MAX_NB_APPS)) regs_inst (
        .pcie_clk          (pcie_clk),
        .pcie_reset_n      (pcie_reset_n),
        .address           (pcie_address_0),
        .read              (pcie_read_0),
        .write             (pcie_write_0),
        .writedata         (pcie_writedata_0),
        .byteenable        (pcie_byteenable_0),
        .reg_readdata      (reg_readdata),
        .reg_readdatavalid (reg_readdatavalid),
        .disable_pcie      (disable_pcie),
        .ring              (ring.regs_side)
    );

    f2c_ring #(
        .RB_DEPTH           (RB_DEPTH),
        .ALMOST_FULL_MARGIN (ALMOST_FULL_MARGIN)
    ) ring_inst (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .wr_en              (pcie_rb_wr_en),
        .wr_addr            (pcie_rb_wr_addr),
        .wr_data            (pcie_rb_wr_data),
        .update_valid       (pcie_rb_update_valid),
        .update_size        (pcie_rb_update_size),
        .wr_base_addr       (pcie_rb_wr_base_addr),
        .wr_base_addr_valid (pcie_rb_wr_base_addr_valid),
        .almost_full        (pcie_rb_almost_full),
        .desc_ready         (pcie_wrdm_desc_ready),
        .desc_valid         (pcie_wrdm_desc_valid),
        .desc_data          (pcie_wrdm_desc_data),
        .buf_read           (buf_read),
        .buf_line           (buf_line),
        .buf_readdata       (buf_readdata),
        .buf_readvalid      (buf_readvalid),
        .ring               (ring.ring_side)
    );

endmodule

//--- hdl/pio_regs.sv
`timescale 1ns/10ps

module pio_regs #(
    parameter int MAX_NB_APPS = 4
) (
    input  logic                                 pcie_clk,
    input  logic                                 pcie_reset_n,
    input  logic [pcie_pkg::PCIE_ADDR_WIDTH-1:0] address,
    input  logic                                 read,
    input  logic                                 write,
    input  pcie_pkg::flit_t                      writedata,
    input  logic [pcie_pkg::FLIT_WIDTH/8-1:0]    byteenable,
    output pcie_pkg::flit_t                      reg_readdata,
    output logic                                 reg_readdatavalid,
    output logic                                 disable_pcie,
    ring_ctrl_if.regs_side                       ring
);

    localparam int APP_IDX_WIDTH = $clog2(MAX_NB_APPS);
    localparam int LINE_WIDTH    = pcie_pkg::PCIE_ADDR_WIDTH - 6;
    localparam int CTRL_LINE     = int'(pcie_pkg::CTRL_BYTE_ADDR) >> 6;
    localparam int PTR_WIDTH     = pcie_pkg::RB_SIZE_WIDTH;
    localparam int PAGE_BITS     = 32 * pcie_pkg::REGS_PER_PAGE;

    pcie_pkg::ctrl_t          ctrl;
    logic [PTR_WIDTH-1:0]     tails     [MAX_NB_APPS];
    logic [31:0]              heads     [MAX_NB_APPS];
    logic [31:0]              kmem_low  [MAX_NB_APPS];
    logic [31:0]              kmem_high [MAX_NB_APPS];
    logic [APP_IDX_WIDTH-1:0] app_id;

    logic [LINE_WIDTH-1:0]    line;
    logic [APP_IDX_WIDTH-1:0] page;
    logic                     page_hit;
    logic                     ctrl_hit;
    logic                     reg_region;

    logic                     rd_v1;
    logic                     rd_ctrl1;
    logic                     rd_page_hit1;
    logic [APP_IDX_WIDTH-1:0] rd_page1;
    logic [PAGE_BITS-1:0]     page_dwords;

    // a dword is written only when all four of its byte lanes are enabled
    function automatic logic dw_full(input logic [pcie_pkg::FLIT_WIDTH/8-1:0] be,
                                     input pcie_pkg::reg_off_e off);
        return &be[4*int'(off) +: 4];
    endfunction

    assign line       = address[pcie_pkg::PCIE_ADDR_WIDTH-1:6];
    assign page       = line[APP_IDX_WIDTH-1:0];
    assign page_hit   = line < MAX_NB_APPS;
    assign ctrl_hit   = line == CTRL_LINE;
    assign reg_region = line < pcie_pkg::RB_BRAM_OFFSET;

    // host writes, tail is owned by the ring engine
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            ctrl <= '{total_apps: 5'd1, rb_size: '0, disable_bit: 1'b1};
            for (int i = 0; i < MAX_NB_APPS; i++) begin
                heads[i]     <= '0;
                kmem_low[i]  <= '0;
                kmem_high[i] <= '0;
            end
        end else if (write) begin
            if (page_hit) begin
                if (dw_full(byteenable, pcie_pkg::REG_HEAD)) begin
                    heads[page] <= writedata[32*int'(pcie_pkg::REG_HEAD) +: 32];
                end
                if (dw_full(byteenable, pcie_pkg::REG_KMEM_LOW)) begin
                    kmem_low[page] <= writedata[32*int'(pcie_pkg::REG_KMEM_LOW) +: 32];
                end
                if (dw_full(byteenable, pcie_pkg::REG_KMEM_HIGH)) begin
                    kmem_high[page] <= writedata[32*int'(pcie_pkg::REG_KMEM_HIGH) +: 32];
                end
            end
            if (ctrl_hit && (&byteenable[3:0])) begin
                ctrl <= pcie_pkg::ctrl_t'(writedata[31:0]);
            end
        end
    end

    // round robin over active apps, tail stored on completion
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            for (int i = 0; i < MAX_NB_APPS; i++) begin
                tails[i] <= '0;
            end
            app_id         <= '0;
            ring.tail      <= '0;
            ring.kmem_addr <= '0;
        end else begin
            if (ring.dma_done) begin
                tails[app_id] <= ring.new_tail;
                if (int'(app_id) + 1 >= int'(ctrl.total_apps)) begin
                    app_id <= '0;
                end else begin
                    app_id <= app_id + 1'b1;
                end
            end
            // selected pointers lag app_id by one cycle
            ring.tail      <= tails[app_id];
            ring.kmem_addr <= {kmem_high[app_id], kmem_low[app_id]};
        end
    end

    assign ring.app_id      = app_id;
    assign ring.rb_size     = ctrl.rb_size;
    assign ring.ring_enable = !ctrl.disable_bit;
    assign disable_pcie     = ctrl.disable_bit;

    // read stage 1: decode
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            rd_v1             <= 1'b0;
            reg_readdatavalid <= 1'b0;
        end else begin
            rd_v1             <= read && reg_region;
            reg_readdatavalid <= rd_v1;
        end
    end

    assign page_dwords = {kmem_high[rd_page1], kmem_low[rd_page1],
                          heads[rd_page1], 32'(tails[rd_page1])};

    // read stage 2: output mux
    always_ff @(posedge pcie_clk) begin
        rd_ctrl1     <= ctrl_hit;
        rd_page_hit1 <= page_hit;
        rd_page1     <= page;
        reg_readdata <= '0;
        if (rd_ctrl1) begin
            reg_readdata[31:0] <= ctrl;
        end else if (rd_page_hit1) begin
            reg_readdata[PAGE_BITS-1:0] <= page_dwords;
        end
    end

    // completions must never walk app_id past the active count
    assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        !ctrl.disable_bit |-> (int'(app_id) < int'(ctrl.total_apps)))
        else $error("app_id %0d not below total_apps %0d", app_id, ctrl.total_apps);

endmodule

//--- hdl/ring_ctrl_if.sv
`timescale 1ns/10ps

interface ring_ctrl_if #(
    parameter int MAX_NB_APPS = 4
);
    localparam int APP_IDX_WIDTH = $clog2(MAX_NB_APPS);

    // pointers of the application whose turn it is
    logic [pcie_pkg::RB_SIZE_WIDTH-1:0] tail;
    logic [63:0]                        kmem_addr;
    logic [APP_IDX_WIDTH-1:0]           app_id;
    logic [pcie_pkg::RB_SIZE_WIDTH-1:0] rb_size;
    logic                               ring_enable;

    // completion from the ring engine
    logic                               dma_done;
    logic [pcie_pkg::RB_SIZE_WIDTH-1:0] new_tail;

    modport regs_side (
        output tail, kmem_addr, app_id, rb_size, ring_enable,
        input  dma_done, new_tail
    );

    modport ring_side (
        input  tail, kmem_addr, app_id, rb_size, ring_enable,
        output dma_done, new_tail
    );

endinterface

//--- src.f
hdl/pcie_pkg.sv
hdl/ring_ctrl_if.sv
hdl/pio_regs.sv
hdl/f2c_ring.sv
hdl/pcie_top.sv
verif/tb_pcie_top.sv

//--- verif/tb_pcie_top.sv
`timescale 1ns/10ps

module tb_pcie_top;

    localparam int RB_DEPTH  = 256;
    localparam int RB_AWIDTH = 8;
    localparam int TIMEOUT   = 100;
    localparam int STALL_MAX = 8;
    localparam int CTRL_LINE = int'(pcie_pkg::CTRL_BYTE_ADDR) >> 6;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_PDU, OP_DRAIN, OP_IDLE, OP_FLAGS} op_e;

    // data holds the write value, PDU size, drain mode or idle cycles
    typedef struct packed {
        op_e         op;
        logic [15:0] addr;
        logic [31:0] data;
        logic [15:0] mask;
        logic [3:0]  exp;
    } row_t;

    logic                 pcie_clk;
    logic                 pcie_reset_n;
    logic [15:0]          pcie_address_0;
    logic                 pcie_read_0;
    logic                 pcie_write_0;
    pcie_pkg::flit_t      pcie_writedata_0;
    logic [63:0]          pcie_byteenable_0;
    pcie_pkg::flit_t      pcie_readdata_0;
    logic                 pcie_readdatavalid_0;
    logic                 pcie_rb_wr_en;
    logic [RB_AWIDTH-1:0] pcie_rb_wr_addr;
    pcie_pkg::flit_t      pcie_rb_wr_data;
    logic [RB_AWIDTH-1:0] pcie_rb_wr_base_addr;
    logic                 pcie_rb_wr_base_addr_valid;
    logic                 pcie_rb_almost_full;
    logic                 pcie_rb_update_valid;
    logic [RB_AWIDTH-1:0] pcie_rb_update_size;
    logic                 pcie_wrdm_desc_ready;
    logic                 pcie_wrdm_desc_valid;
    logic [173:0]         pcie_wrdm_desc_data;
    logic                 disable_pcie;

    // reference model state
    logic [31:0]          model_ctrl;
    logic [31:0]          model_head    [4];
    logic [31:0]          model_kmem_lo [4];
    logic [31:0]          model_kmem_hi [4];
    logic [25:0]          model_tail    [4];
    int                   model_app;
    logic [7:0]           model_desc_id;
    logic [RB_AWIDTH-1:0] model_wr_ptr;
    pcie_pkg::flit_t      model_buf [RB_DEPTH];
    logic [RB_AWIDTH-1:0] pdu_start_q [$];
    logic [RB_AWIDTH-1:0] pdu_size_q  [$];

    row_t                 rows [$];
    int                   mismatches;
    int                   timeouts;
    logic [31:0]          rng_state;

    pcie_top UUT (.*);

    initial pcie_clk = 1'b0;
    always #4 pcie_clk = ~pcie_clk;

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic pcie_pkg::flit_t random_flit();
        pcie_pkg::flit_t flit;
        for (int w = 0; w < 16; w++) begin
            flit[32*w +: 32] = xorshift32();
        end
        return flit;
    endfunction

    // line contents the host should see at a PIO byte address
    function automatic pcie_pkg::flit_t expected_line(input logic [15:0] addr);
        pcie_pkg::flit_t line;
        int              idx;
        idx  = int'(addr[15:6]);
        line = '0;
        if (idx >= pcie_pkg::RB_BRAM_OFFSET) begin
            line = model_buf[idx - pcie_pkg::RB_BRAM_OFFSET];
        end else if (idx == CTRL_LINE) begin
            line[31:0] = model_ctrl;
        end else if (idx < 4) begin
            line[127:0] = {model_kmem_hi[idx], model_kmem_lo[idx], model_head[idx],
                           6'd0, model_tail[idx]};
        end
        return line;
    endfunction

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            mismatches++;
            $display("mismatch at %0t: %s", $time, what);
        end
    endtask

    task automatic next_cycle();
        @(posedge pcie_clk);
        #1;
    endtask

    task automatic add_row(input op_e op, input logic [15:0] addr, input logic [31:0] data,
                           input logic [15:0] mask, input logic [3:0] exp);
        rows.push_back('{op: op, addr: addr, data: data, mask: mask, exp: exp});
    endtask

    // data is replicated into every dword, the mask picks the lanes
    task automatic pio_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [15:0] mask);
        int idx;
        idx = int'(addr[15:6]);
        next_cycle();
        pcie_address_0    = addr;
        pcie_write_0      = 1'b1;
        pcie_writedata_0  = {16{data}};
        pcie_byteenable_0 = 64'(mask);
        next_cycle();
        pcie_write_0      = 1'b0;
        pcie_byteenable_0 = '0;
        if (idx < 4) begin
            if (&mask[7:4]) begin
                model_head[idx] = data;
            end
            if (&mask[11:8]) begin
                model_kmem_lo[idx] = data;
            end
            if (&mask[15:12]) begin
                model_kmem_hi[idx] = data;
            end
        end else if (idx == CTRL_LINE && (&mask[3:0])) begin
            model_ctrl = data;
        end
    endtask

    task automatic pio_read_check(input logic [15:0] addr);
        pcie_pkg::flit_t want;
        int              cycles;
        want = expected_line(addr);
        next_cycle();
        pcie_address_0 = addr;
        pcie_read_0    = 1'b1;
        next_cycle();
        pcie_read_0 = 1'b0;
        cycles      = 1;
        while (!pcie_readdatavalid_0 && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (!pcie_readdatavalid_0) begin
            timeouts++;
            $display("timeout: no read data for address %h after %0d cycles", addr, cycles);
        end else begin
            check(cycles == 2, $sformatf("read %h answered after %0d cycles, expected 2",
                                         addr, cycles));
            check(pcie_readdata_0 == want, $sformatf("read %h got %h expected %h", addr,
                                                     pcie_readdata_0[127:0], want[127:0]));
        end
    endtask

    // flits go in at the base address, then one update strobe
    task automatic send_pdu(input int size);
        logic [RB_AWIDTH-1:0] start;
        pcie_pkg::flit_t      flit;
        start = model_wr_ptr;
        next_cycle();
        check(pcie_rb_wr_base_addr_valid && pcie_rb_wr_base_addr == start,
              $sformatf("base address %0d expected %0d", pcie_rb_wr_base_addr, start));
        for (int i = 0; i < size; i++) begin
            flit                               = random_flit();
            pcie_rb_wr_en                      = 1'b1;
            pcie_rb_wr_addr                    = start + RB_AWIDTH'(i);
            pcie_rb_wr_data                    = flit;
            model_buf[start + RB_AWIDTH'(i)]   = flit;
            next_cycle();
        end
        pcie_rb_wr_en        = 1'b0;
        pcie_rb_update_valid = 1'b1;
        pcie_rb_update_size  = RB_AWIDTH'(size);
        next_cycle();
        pcie_rb_update_valid = 1'b0;
        model_wr_ptr         = start + RB_AWIDTH'(size);
        pdu_start_q.push_back(start);
        pdu_size_q.push_back(RB_AWIDTH'(size));
    endtask

    task automatic drain_descriptors(input logic random_stalls);
        pcie_pkg::wrdm_desc_t want;
        pcie_pkg::wrdm_desc_t held;
        logic [RB_AWIDTH-1:0] start;
        logic [RB_AWIDTH-1:0] size;
        logic [26:0]          tail_sum;
        logic [31:0]          rnd;
        int                   cycles;
        logic                 done;
        while (pdu_size_q.size() > 0) begin
            start  = pdu_start_q.pop_front();
            size   = pdu_size_q.pop_front();
            cycles = 0;
            while (!pcie_wrdm_desc_valid && cycles < TIMEOUT) begin
                next_cycle();
                cycles++;
            end
            if (!pcie_wrdm_desc_valid) begin
                timeouts++;
                $display("timeout: no descriptor for the PDU at slot %0d", start);
                return;
            end
            want.dest_addr = {model_kmem_hi[model_app], model_kmem_lo[model_app]}
                             + (64'(model_tail[model_app]) << 6);
            want.src_addr  = 64'(start) << 6;
            want.size_dw   = 18'(size) * 18'd16;
            want.desc_id   = model_desc_id;
            want.app_id    = 4'(model_app);
            want.rsvd      = '0;
            held           = pcie_wrdm_desc_data;
            check(held == want, $sformatf("descriptor got %h expected %h", held, want));
            // last try always accepts
            done = 1'b0;
            for (int k = 0; k < STALL_MAX && !done; k++) begin
                rnd = xorshift32();
                pcie_wrdm_desc_ready = !random_stalls || k == STALL_MAX - 1 || rnd[1:0] == 2'b00;
                next_cycle();
                if (pcie_wrdm_desc_ready) begin
                    done = 1'b1;
                end else begin
                    check(pcie_wrdm_desc_valid && pcie_wrdm_desc_data == held,
                          "descriptor changed during a ready stall");
                end
            end
            pcie_wrdm_desc_ready = 1'b0;
            tail_sum = 27'(model_tail[model_app]) + 27'(size);
            if (tail_sum >= 27'(model_ctrl[26:1])) begin
                tail_sum = tail_sum - 27'(model_ctrl[26:1]);
            end
            model_tail[model_app] = tail_sum[25:0];
            model_app = (model_app + 1 >= int'(model_ctrl[31:27])) ? 0 : model_app + 1;
            model_desc_id++;
        end
    endtask

    task automatic check_flags(input logic [3:0] want);
        logic [3:0] got;
        next_cycle();
        got = {pcie_readdatavalid_0, pcie_wrdm_desc_valid, pcie_rb_almost_full, disable_pcie};
        check(got == want, $sformatf("{readdatavalid, desc_valid, almost_full, disable} %b, expected %b",
                                     got, want));
    endtask

    initial begin
        pcie_reset_n         = 1'b0;
        pcie_address_0       = '0;
        pcie_read_0          = 1'b0;
        pcie_write_0         = 1'b0;
        pcie_writedata_0     = '0;
        pcie_byteenable_0    = '0;
        pcie_rb_wr_en        = 1'b0;
        pcie_rb_wr_addr      = '0;
        pcie_rb_wr_data      = '0;
        pcie_rb_update_valid = 1'b0;
        pcie_rb_update_size  = '0;
        pcie_wrdm_desc_ready = 1'b0;
        rng_state            = 32'h85e8_b778;
        mismatches           = 0;
        timeouts             = 0;
        model_ctrl           = 32'h0800_0001;
        model_app            = 0;
        model_desc_id        = '0;
        model_wr_ptr         = '0;
        for (int i = 0; i < 4; i++) begin
            model_head[i]    = '0;
            model_kmem_lo[i] = '0;
            model_kmem_hi[i] = '0;
            model_tail[i]    = '0;
        end
        for (int i = 0; i < RB_DEPTH; i++) begin
            model_buf[i] = '0;
        end

        // state after reset
        add_row(OP_FLAGS, 16'h0000, 32'h0, 16'h0, 4'b0001);
        add_row(OP_READ,  16'h0000, 32'h0, 16'h0, 4'b0000);
        add_row(OP_READ,  16'h00c0, 32'h0, 16'h0, 4'b0000);
        add_row(OP_READ,  16'h0800, 32'h0, 16'h0, 4'b0000);
        // page writes, partial lanes and the read-only tail
        add_row(OP_WRITE, 16'h0000, 32'h1000_0040, 16'hffff, 4'b0000);
        add_row(OP_WRITE, 16'h0040, 32'h2000_0080, 16'hffff, 4'b0000);
        add_row(OP_WRITE, 16'h0080, 32'h3000_00c0, 16'hffff, 4'b0000);
        add_row(OP_WRITE, 16'h0040, 32'h2222_0100, 16'h0f0f, 4'b0000);
        add_row(OP_WRITE, 16'h0040, 32'h2333_0200, 16'h30f0, 4'b0000);
        add_row(OP_WRITE, 16'h0040, 32'hdead_beef, 16'h000f, 4'b0000);
        add_row(OP_READ,  16'h0000, 32'h0, 16'h0, 4'b0000);
        add_row(OP_READ,  16'h0040, 32'h0, 16'h0, 4'b0000);
        add_row(OP_READ,  16'h0080, 32'h0, 16'h0, 4'b0000);
        // held while disabled, then three apps and rb_size 12
        add_row(OP_PDU,   16'h0000, 32'd4, 16'h0, 4'b0000);
        add_row(OP_IDLE,  16'h0000, 32'd6, 16'h0, 4'b0000);
        add_row(OP_FLAGS, 16'h0000, 32'h0, 16'h0, 4'b0001);
        add_row(OP_WRITE, 16'h0800, 32'h1800_0018, 16'h000f, 4'b0000);
        add_row(OP_DRAIN, 16'h0000, 32'd1, 16'h0, 4'b0000);
        add_row(OP_FLAGS, 16'h0000, 32'h0, 16'h0, 4'b0000);
        // round robin with stalls, tails wrap
        add_row(OP_PDU,   16'h0000, 32'd5, 16'h0, 4'b0000);
        add_row(OP_PDU,   16'h0000, 32'd7, 16'h0, 4'b0000);
        add_row(OP_DRAIN, 16'h0000, 32'd1, 16'h0, 4'b0000);
        add_row(OP_PDU,   16'h0000, 32'd3, 16'h0, 4'b0000);
        add_row(OP_DRAIN, 16'h0000, 32'd1, 16'h0, 4'b0000);
        add_row(OP_PDU,   16'h0000, 32'd8, 16'h0, 4'b0000);
        add_row(OP_PDU,   16'h0000, 32'd2, 16'h0, 4'b0000);
        add_row(OP_DRAIN, 16'h0000, 32'd1, 16'h0, 4'b0000);
        add_row(OP_PDU,   16'h0000, 32'd6, 16'h0, 4'b0000);
        add_row(OP_DRAIN, 16'h0000, 32'd1, 16'h0, 4'b0000);
        add_row(OP_READ,  16'h0000, 32'h0, 16'h0, 4'b0000);
        add_row(OP_READ,  16'h0040, 32'h0, 16'h0, 4'b0000);
        add_row(OP_READ,  16'h0080, 32'h0, 16'h0, 4'b0000);
        // buffer window, slots 0, 9 and 34
        add_row(OP_READ,  16'h1000, 32'h0, 16'h0, 4'b0000);
        add_row(OP_READ,  16'h1240, 32'h0, 16'h0, 4'b0000);
        add_row(OP_READ,  16'h1880, 32'h0, 16'h0, 4'b0000);
        // fill to 250 slots with ready low
        add_row(OP_WRITE, 16'h0800, 32'h1800_07d0, 16'h000f, 4'b0000);
        add_row(OP_PDU,   16'h0000, 32'd200, 16'h0, 4'b0000);
        add_row(OP_PDU,   16'h0000, 32'd50, 16'h0, 4'b0000);
        add_row(OP_FLAGS, 16'h0000, 32'h0, 16'h0, 4'b0110);
        add_row(OP_DRAIN, 16'h0000, 32'd0, 16'h0, 4'b0000);
        add_row(OP_FLAGS, 16'h0000, 32'h0, 16'h0, 4'b0000);
        add_row(OP_READ,  16'h10c0, 32'h0, 16'h0, 4'b0000);
        add_row(OP_READ,  16'h0040, 32'h0, 16'h0, 4'b0000);

        repeat (16) @(posedge pcie_clk);
        #1;
        pcie_reset_n = 1'b1;

        foreach (rows[i]) begin
            case (rows[i].op)
                OP_WRITE: pio_write(rows[i].addr, rows[i].data, rows[i].mask);
                OP_READ:  pio_read_check(rows[i].addr);
                OP_PDU:   send_pdu(int'(rows[i].data));
                OP_DRAIN: drain_descriptors(rows[i].data[0]);
                OP_IDLE:  repeat (int'(rows[i].data)) next_cycle();
                default:  check_flags(rows[i].exp);
            endcase
        end

        repeat (4) next_cycle();
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
